//--- rtl/mcu_pkg.sv
// shared bus types, register map and sizes for the mcu control subsystem
// compiled first; rtl and testbench pick what they need from here
package mcu_pkg;

  // sizes
  localparam int GPIO_W      = 20;
  localparam int BUS_AW      = 8;
  localparam int BUS_DW      = 32;
  localparam int LED_COUNT_W = 27;

  // one request per valid strobe, no back-pressure
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
  } reg_req_t;

  // ack pulses one cycle after valid
  typedef struct packed {
    logic              ack;
    logic              error;
    logic [BUS_DW-1:0] rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic [GPIO_W-1:0] out;
    logic [GPIO_W-1:0] oe;
  } gpio_ctrl_t;

  typedef struct packed {
    logic [GPIO_W-1:0] in_sync;
    logic [GPIO_W-1:0] rise;
  } gpio_stat_t;

  // register byte offsets
  localparam logic [BUS_AW-1:0] ADDR_SCRATCH     = 8'h00;
  localparam logic [BUS_AW-1:0] ADDR_BOOT_INFO   = 8'h04;
  localparam logic [BUS_AW-1:0] ADDR_GPIO_OUT    = 8'h08;
  localparam logic [BUS_AW-1:0] ADDR_GPIO_OE     = 8'h0C;
  localparam logic [BUS_AW-1:0] ADDR_GPIO_IN     = 8'h10;
  localparam logic [BUS_AW-1:0] ADDR_RISE_STATUS = 8'h14;
  localparam logic [BUS_AW-1:0] ADDR_RISE_EN     = 8'h18;
  localparam logic [BUS_AW-1:0] ADDR_EXIT        = 8'h1C;

  // boot info bit positions
  localparam int BOOT_SELECT_BIT = 0;
  localparam int EXEC_FLASH_BIT  = 1;

endpackage

//--- rtl/board_clock_reset.sv
// board clock and reset conditioning: halves the board clock into clk_gen,
// builds rst_n with synchronous release and runs the heartbeat counter
`timescale 1ns/10ps

module board_clock_reset #(
  parameter int CLK_LED_COUNT_LENGTH = mcu_pkg::LED_COUNT_W
) (
  input  logic clk_i,
  input  logic rst_i,
  output logic clk_gen_o,
  output logic rst_n_o,
  output logic clk_led_o
);

  // stands in for the clock wizard, free running from configuration
  logic clk_div = 1'b0;

  logic rst_pad_n;
  logic [1:0] rst_sync_q;
  logic [CLK_LED_COUNT_LENGTH-1:0] led_count_q;

  always_ff @(posedge clk_i) begin
    clk_div <= ~clk_div;
  end

  assign clk_gen_o = clk_div;

  // board reset is active high
  assign rst_pad_n = ~rst_i;

  // asserts at once, releases after two clk_gen edges
  always_ff @(posedge clk_gen_o or negedge rst_pad_n) begin
    if (!rst_pad_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_n_o = rst_sync_q[1];

  // heartbeat
  always_ff @(posedge clk_gen_o or negedge rst_n_o) begin
    if (!rst_n_o) begin
      led_count_q <= '0;
    end else begin
      led_count_q <= led_count_q + 1'b1;
    end
  end

  assign clk_led_o = led_count_q[CLK_LED_COUNT_LENGTH-1];

endmodule

//--- rtl/soc_ctrl_regs.sv
// control register block on the strobe bus: scratch, boot straps, gpio
// control, rising-edge interrupt status and the exit report
`timescale 1ns/10ps

module soc_ctrl_regs (
  input  logic                clk_gen,
  input  logic                rst_n,
  input  mcu_pkg::reg_req_t   reg_req_i,
  output mcu_pkg::reg_rsp_t   reg_rsp_o,
  input  logic                boot_select_i,
  input  logic                execute_from_flash_i,
  output mcu_pkg::gpio_ctrl_t gpio_ctrl_o,
  input  mcu_pkg::gpio_stat_t gpio_stat_i,
  output logic                gpio_intr_o,
  output logic [31:0]         exit_value_o,
  output logic                exit_valid_o
);

  import mcu_pkg::*;

  logic [BUS_DW-1:0] scratch_q;
  logic [1:0]        boot_q;
  logic [GPIO_W-1:0] gpio_out_q;
  logic [GPIO_W-1:0] gpio_oe_q;
  logic [GPIO_W-1:0] rise_status_q;
  logic [GPIO_W-1:0] rise_en_q;
  logic [BUS_DW-1:0] exit_value_q;
  logic              exit_valid_q;
  logic              intr_q;
  reg_rsp_t          rsp_q;

  logic              addr_hit;
  logic              wr_en;
  logic [BUS_DW-1:0] rdata_d;
  logic [GPIO_W-1:0] rise_clr;

  // address decode and read mux
  always_comb begin
    rdata_d  = '0;
    addr_hit = 1'b1;
    case (reg_req_i.addr)
      ADDR_SCRATCH:     rdata_d = scratch_q;
      ADDR_BOOT_INFO:   rdata_d[1:0] = boot_q;
      ADDR_GPIO_OUT:    rdata_d[GPIO_W-1:0] = gpio_out_q;
      ADDR_GPIO_OE:     rdata_d[GPIO_W-1:0] = gpio_oe_q;
      ADDR_GPIO_IN:     rdata_d[GPIO_W-1:0] = gpio_stat_i.in_sync;
      ADDR_RISE_STATUS: rdata_d[GPIO_W-1:0] = rise_status_q;
      ADDR_RISE_EN:     rdata_d[GPIO_W-1:0] = rise_en_q;
      ADDR_EXIT:        rdata_d = exit_value_q;
      default:          addr_hit = 1'b0;
    endcase
  end

  assign wr_en = reg_req_i.valid & reg_req_i.write & addr_hit;

  assign rise_clr = (wr_en && reg_req_i.addr == ADDR_RISE_STATUS) ?
                    reg_req_i.wdata[GPIO_W-1:0] : '0;

  // writable registers
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      scratch_q    <= '0;
      gpio_out_q   <= '0;
      gpio_oe_q    <= '0;
      rise_en_q    <= '0;
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
    end else if (wr_en) begin
      case (reg_req_i.addr)
        ADDR_SCRATCH:  scratch_q  <= reg_req_i.wdata;
        ADDR_GPIO_OUT: gpio_out_q <= reg_req_i.wdata[GPIO_W-1:0];
        ADDR_GPIO_OE:  gpio_oe_q  <= reg_req_i.wdata[GPIO_W-1:0];
        ADDR_RISE_EN:  rise_en_q  <= reg_req_i.wdata[GPIO_W-1:0];
        ADDR_EXIT: begin
          exit_value_q <= reg_req_i.wdata;
          // sticky until reset
          exit_valid_q <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  // edge status, a new rise beats a clear in the same cycle
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      rise_status_q <= '0;
      intr_q        <= 1'b0;
      boot_q        <= 2'b00;
    end else begin
      rise_status_q <= (rise_status_q & ~rise_clr) | gpio_stat_i.rise;
      intr_q        <= |(rise_status_q & rise_en_q);
      boot_q[BOOT_SELECT_BIT] <= boot_select_i;
      boot_q[EXEC_FLASH_BIT]  <= execute_from_flash_i;
    end
  end

  // response one cycle after the request
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      rsp_q <= '0;
    end else begin
      rsp_q.ack   <= reg_req_i.valid;
      rsp_q.error <= reg_req_i.valid & ~addr_hit;
      rsp_q.rdata <= (reg_req_i.valid & ~reg_req_i.write) ? rdata_d : '0;
    end
  end

  assign reg_rsp_o       = rsp_q;
  assign gpio_ctrl_o.out = gpio_out_q;
  assign gpio_ctrl_o.oe  = gpio_oe_q;
  assign gpio_intr_o     = intr_q;
  assign exit_value_o    = exit_value_q;
  assign exit_valid_o    = exit_valid_q;

endmodule

//--- rtl/gpio_port.sv
// gpio pad logic: tristate drivers per pin, two-flop input synchronizer
// and one-cycle rising-edge pulses for the register block
`timescale 1ns/10ps

module gpio_port (
  input  logic                       clk_gen,
  input  logic                       rst_n,
  inout  logic [mcu_pkg::GPIO_W-1:0] gpio_io,
  input  mcu_pkg::gpio_ctrl_t        gpio_ctrl_i,
  output mcu_pkg::gpio_stat_t        gpio_stat_o
);

  import mcu_pkg::*;

  logic [GPIO_W-1:0] meta_q;
  logic [GPIO_W-1:0] sync_q;
  logic [GPIO_W-1:0] rise;

  // released pins float
  for (genvar i = 0; i < GPIO_W; i++) begin : g_pad
    assign gpio_io[i] = gpio_ctrl_i.oe[i] ? gpio_ctrl_i.out[i] : 1'bz;
  end

  // pads are asynchronous to clk_gen
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= gpio_io;
      sync_q <= meta_q;
    end
  end

  // compare next synchronized value with the current one
  // so the pulse lands on the edge that updates in_sync
  assign rise = meta_q & ~sync_q;

  assign gpio_stat_o.in_sync = sync_q;
  assign gpio_stat_o.rise    = rise;

endmodule

//--- rtl/mini_mcu_system.sv
// control subsystem placed next to the board clock and reset logic
// register block steering the gpio port
`timescale 1ns/10ps

module mini_mcu_system (
  input  logic                       clk_gen,
  input  logic                       rst_n,
  input  mcu_pkg::reg_req_t          reg_req_i,
  output mcu_pkg::reg_rsp_t          reg_rsp_o,
  input  logic                       boot_select_i,
  input  logic                       execute_from_flash_i,
  inout  logic [mcu_pkg::GPIO_W-1:0] gpio_io,
  output logic                       gpio_intr_o,
  output logic [31:0]                exit_value_o,
  output logic                       exit_valid_o
);

  import mcu_pkg::*;

  gpio_ctrl_t gpio_ctrl;
  gpio_stat_t gpio_stat;

  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_gen              (clk_gen),
    .rst_n                (rst_n),
    .reg_req_i            (reg_req_i),
    .reg_rsp_o            (reg_rsp_o),
    .boot_select_i        (boot_select_i),
    .execute_from_flash_i (execute_from_flash_i),
    .gpio_ctrl_o          (gpio_ctrl),
    .gpio_stat_i          (gpio_stat),
    .gpio_intr_o          (gpio_intr_o),
    .exit_value_o         (exit_value_o),
    .exit_valid_o         (exit_valid_o)
  );

  gpio_port i_gpio_port (
    .clk_gen     (clk_gen),
    .rst_n       (rst_n),
    .gpio_io     (gpio_io),
    .gpio_ctrl_i (gpio_ctrl),
    .gpio_stat_o (gpio_stat)
  );

endmodule

//--- rtl/board_wrapper.sv
// fpga board top: clock and reset conditioning, debug leds and clock out,
// and the control subsystem reached through the external register bus
`timescale 1ns/10ps

module board_wrapper #(
  parameter int CLK_LED_COUNT_LENGTH = mcu_pkg::LED_COUNT_W
) (
  input  logic                       clk_i,
  input  logic                       rst_i,

  // register bus, driven by a debug bridge on the board
  input  mcu_pkg::reg_req_t          reg_req_i,
  output mcu_pkg::reg_rsp_t          reg_rsp_o,

  input  logic                       boot_select_i,
  input  logic                       execute_from_flash_i,

  inout  logic [mcu_pkg::GPIO_W-1:0] gpio_io,
  output logic                       gpio_intr_o,

  output logic                       exit_value_o,
  output logic                       exit_valid_o,

  // visibility
  output logic                       rst_led_o,
  output logic                       clk_led_o,
  output logic                       clk_out_o
);

  logic        clk_gen;
  logic        rst_n;
  logic [31:0] exit_value;

  board_clock_reset #(
    .CLK_LED_COUNT_LENGTH (CLK_LED_COUNT_LENGTH)
  ) i_board_clock_reset (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .clk_gen_o (clk_gen),
    .rst_n_o   (rst_n),
    .clk_led_o (clk_led_o)
  );

  mini_mcu_system i_mini_mcu_system (
    .clk_gen              (clk_gen),
    .rst_n                (rst_n),
    .reg_req_i            (reg_req_i),
    .reg_rsp_o            (reg_rsp_o),
    .boot_select_i        (boot_select_i),
    .execute_from_flash_i (execute_from_flash_i),
    .gpio_io              (gpio_io),
    .gpio_intr_o          (gpio_intr_o),
    .exit_value_o         (exit_value),
    .exit_valid_o         (exit_valid_o)
  );

  assign clk_out_o = clk_gen;
  assign rst_led_o = rst_n;

  // only the pass/fail bit reaches a pin
  assign exit_value_o = exit_value[0];

endmodule

//--- tb/tb_board_wrapper.sv
// table-driven testbench for the board wrapper that drives the register bus,
// straps and pins from a row table and checks responses and board outputs
`timescale 1ns/10ps

module tb_board_wrapper;

  import mcu_pkg::*;

  localparam int LED_LEN    = 5;
  localparam int CLK_PERIOD = 8;

  // table operations
  localparam logic [2:0] OP_WRITE = 3'd0;
  localparam logic [2:0] OP_READ  = 3'd1;
  localparam logic [2:0] OP_PIN   = 3'd2;
  localparam logic [2:0] OP_STRAP = 3'd3;
  localparam logic [2:0] OP_WAIT  = 3'd4;
  localparam logic [2:0] OP_PADS  = 3'd5;
  localparam logic [2:0] OP_OUTS  = 3'd6;

  // sel is a bus address or a pin mask
  typedef struct packed {
    logic [2:0]  op;
    logic [31:0] sel;
    logic [31:0] data;
    logic [31:0] expd;
    logic        exp_err;
  } row_t;

  logic              clk_i;
  logic              rst_i;
  reg_req_t          reg_req;
  reg_rsp_t          reg_rsp;
  logic              boot_select;
  logic              execute_from_flash;
  wire  [GPIO_W-1:0] gpio_io;
  logic              gpio_intr;
  logic              exit_value;
  logic              exit_valid;
  logic              rst_led;
  logic              clk_led;
  logic              clk_out;

  logic [GPIO_W-1:0] pin_oe;
  logic [GPIO_W-1:0] pin_val;

  row_t        table_q[$];
  logic [31:0] lcg_state;
  int          cycle_count = 0;
  int          timeout_limit = 0;

  board_wrapper #(
    .CLK_LED_COUNT_LENGTH (LED_LEN)
  ) i_board_wrapper (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .reg_req_i            (reg_req),
    .reg_rsp_o            (reg_rsp),
    .boot_select_i        (boot_select),
    .execute_from_flash_i (execute_from_flash),
    .gpio_io              (gpio_io),
    .gpio_intr_o          (gpio_intr),
    .exit_value_o         (exit_value),
    .exit_valid_o         (exit_valid),
    .rst_led_o            (rst_led),
    .clk_led_o            (clk_led),
    .clk_out_o            (clk_out)
  );

  // external pin drivers with one enable per pin
  for (genvar i = 0; i < GPIO_W; i++) begin : g_pin_drv
    assign gpio_io[i] = pin_oe[i] ? pin_val[i] : 1'bz;
  end

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_out) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("Test failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
    if (actual !== expected) begin
      $display("mismatch at %0d ns: %s (got %h, expected %h)", $time, what, actual,
               expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic add_row(input logic [2:0] op, input logic [31:0] sel,
                         input logic [31:0] data, input logic [31:0] expd,
                         input logic exp_err);
    row_t row;
    row.op      = op;
    row.sel     = sel;
    row.data    = data;
    row.expd    = expd;
    row.exp_err = exp_err;
    table_q.push_back(row);
  endtask

  // one request strobe with the response checked one cycle later
  task automatic bus_access(input logic write, input logic [BUS_AW-1:0] addr,
                            input logic [BUS_DW-1:0] wdata,
                            input logic [BUS_DW-1:0] exp_rdata, input logic exp_err);
    reg_req_t req;
    string    tag;
    req.valid = 1'b1;
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
    tag = $sformatf("%s 0x%02h", write ? "write" : "read", addr);
    @(posedge clk_out);
    reg_req <= req;
    @(negedge clk_out);
    compare_value({31'b0, reg_rsp.ack}, 32'd0, {tag, " ack too early"});
    @(posedge clk_out);
    reg_req <= '0;
    @(negedge clk_out);
    compare_value({31'b0, reg_rsp.ack}, 32'd1, {tag, " ack"});
    compare_value({31'b0, reg_rsp.error}, {31'b0, exp_err}, {tag, " error"});
    if (!write) begin
      compare_value(reg_rsp.rdata, exp_rdata, {tag, " data"});
    end
  endtask

  task automatic verify_idle_outputs(input string when);
    compare_value({31'b0, reg_rsp.ack}, 32'd0, {"ack ", when});
    compare_value({31'b0, reg_rsp.error}, 32'd0, {"error ", when});
    compare_value({31'b0, exit_valid}, 32'd0, {"exit valid ", when});
    compare_value({31'b0, gpio_intr}, 32'd0, {"interrupt ", when});
    compare_value({31'b0, clk_led}, 32'd0, {"heartbeat led ", when});
    compare_value({12'b0, gpio_io}, {12'b0, {GPIO_W{1'bz}}}, {"pins ", when});
  endtask

  task automatic build_table();
    lcg_state = 32'd48;
    // strap value bit 0 drives boot select and bit 1 execute from flash
    for (int s = 0; s < 4; s++) begin
      add_row(OP_STRAP, '0, s, '0, 1'b0);
      add_row(OP_WAIT, '0, 32'd1, '0, 1'b0);
      add_row(OP_READ, ADDR_BOOT_INFO, '0, s, 1'b0);
    end
    for (int k = 0; k < 4; k++) begin
      lcg_state = lcg_next(lcg_state);
      add_row(OP_WRITE, ADDR_SCRATCH, lcg_state, '0, 1'b0);
      add_row(OP_READ, ADDR_SCRATCH, '0, lcg_state, 1'b0);
    end
    // unmapped offsets
    add_row(OP_READ, 32'h20, '0, '0, 1'b1);
    add_row(OP_READ, 32'h80, '0, '0, 1'b1);
    add_row(OP_READ, 32'hFC, '0, '0, 1'b1);
    add_row(OP_WRITE, 32'h24, 32'hFFFF_FFFF, '0, 1'b1);
    add_row(OP_READ, ADDR_SCRATCH, '0, lcg_state, 1'b0);
    // outputs on the low byte only
    add_row(OP_WRITE, ADDR_GPIO_OUT, 32'hABC5_5A3C, '0, 1'b0);
    add_row(OP_READ, ADDR_GPIO_OUT, '0, 32'h0005_5A3C, 1'b0);
    add_row(OP_WRITE, ADDR_GPIO_OE, 32'hFFF0_00FF, '0, 1'b0);
    add_row(OP_READ, ADDR_GPIO_OE, '0, 32'h0000_00FF, 1'b0);
    add_row(OP_PADS, '0, '0, {12'b0, 12'hzzz, 8'h3C}, 1'b0);
    add_row(OP_WRITE, ADDR_GPIO_OUT, 32'h0000_00C3, '0, 1'b0);
    add_row(OP_PADS, '0, '0, {12'b0, 12'hzzz, 8'hC3}, 1'b0);
    // drive the released pins low, then clear stale status
    add_row(OP_PIN, 32'h000F_FF00, '0, '0, 1'b0);
    add_row(OP_WAIT, '0, 32'd4, '0, 1'b0);
    add_row(OP_WRITE, ADDR_RISE_STATUS, 32'hFFFF_FFFF, '0, 1'b0);
    add_row(OP_READ, ADDR_RISE_STATUS, '0, '0, 1'b0);
    add_row(OP_READ, ADDR_GPIO_IN, '0, 32'h0000_00C3, 1'b0);
    // rises on pins 9, 11, 12 and 14
    add_row(OP_PIN, 32'h000F_FF00, 32'h0000_5A00, '0, 1'b0);
    add_row(OP_WAIT, '0, 32'd4, '0, 1'b0);
    add_row(OP_READ, ADDR_GPIO_IN, '0, 32'h0000_5AC3, 1'b0);
    add_row(OP_PADS, '0, '0, 32'h0000_5AC3, 1'b0);
    add_row(OP_READ, ADDR_RISE_STATUS, '0, 32'h0000_5A00, 1'b0);
    // outs holds the interrupt in bit 2, exit valid in bit 1 and exit value in bit 0
    add_row(OP_OUTS, '0, '0, 32'd0, 1'b0);
    add_row(OP_WRITE, ADDR_RISE_EN, 32'h0000_0200, '0, 1'b0);
    add_row(OP_WAIT, '0, 32'd2, '0, 1'b0);
    add_row(OP_OUTS, '0, '0, 32'd4, 1'b0);
    add_row(OP_WRITE, ADDR_RISE_STATUS, 32'h0000_0200, '0, 1'b0);
    add_row(OP_WAIT, '0, 32'd2, '0, 1'b0);
    add_row(OP_OUTS, '0, '0, 32'd0, 1'b0);
    add_row(OP_READ, ADDR_RISE_STATUS, '0, 32'h0000_5800, 1'b0);
    // falling edges leave status alone
    add_row(OP_PIN, 32'h000F_FF00, '0, '0, 1'b0);
    add_row(OP_WAIT, '0, 32'd4, '0, 1'b0);
    add_row(OP_READ, ADDR_RISE_STATUS, '0, 32'h0000_5800, 1'b0);
    add_row(OP_OUTS, '0, '0, 32'd0, 1'b0);
    add_row(OP_WRITE, ADDR_RISE_EN, 32'h0000_0800, '0, 1'b0);
    add_row(OP_WAIT, '0, 32'd2, '0, 1'b0);
    add_row(OP_OUTS, '0, '0, 32'd4, 1'b0);
    add_row(OP_WRITE, ADDR_RISE_STATUS, 32'hFFFF_FFFF, '0, 1'b0);
    add_row(OP_WAIT, '0, 32'd2, '0, 1'b0);
    add_row(OP_OUTS, '0, '0, 32'd0, 1'b0);
    add_row(OP_READ, ADDR_RISE_STATUS, '0, '0, 1'b0);
    // rise on pin 13 with its enable clear
    add_row(OP_PIN, 32'h000F_FF00, 32'h0000_2000, '0, 1'b0);
    add_row(OP_WAIT, '0, 32'd4, '0, 1'b0);
    add_row(OP_READ, ADDR_RISE_STATUS, '0, 32'h0000_2000, 1'b0);
    add_row(OP_OUTS, '0, '0, 32'd0, 1'b0);
    // exit report
    add_row(OP_WRITE, ADDR_EXIT, 32'd1, '0, 1'b0);
    add_row(OP_OUTS, '0, '0, 32'd3, 1'b0);
    add_row(OP_READ, ADDR_EXIT, '0, 32'd1, 1'b0);
    add_row(OP_WRITE, ADDR_EXIT, 32'd2, '0, 1'b0);
    add_row(OP_OUTS, '0, '0, 32'd2, 1'b0);
    add_row(OP_READ, ADDR_EXIT, '0, 32'd2, 1'b0);
    // everything released
    add_row(OP_PIN, '0, '0, '0, 1'b0);
    add_row(OP_WRITE, ADDR_GPIO_OE, '0, '0, 1'b0);
    add_row(OP_PADS, '0, '0, {12'b0, 20'hz_zzzz}, 1'b0);
  endtask

  initial begin
    row_t        row;
    time         t_rise;
    logic [31:0] period_ns;
    rst_i              = 1'b1;
    reg_req            = '0;
    boot_select        = 1'b0;
    execute_from_flash = 1'b0;
    pin_oe             = '0;
    pin_val            = '0;
    build_table();
    timeout_limit = table_q.size() * 10 + 64;

    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    verify_idle_outputs("during reset");
    compare_value({31'b0, rst_led}, 32'd0, "reset led during reset");
    @(posedge clk_i);
    rst_i <= 1'b0;

    // heartbeat counts from the first clk_gen cycle with rst_n high
    @(negedge clk_out);
    while (rst_led !== 1'b1) begin
      @(negedge clk_out);
    end
    verify_idle_outputs("after reset");
    for (int i = 1; i <= 2 ** (LED_LEN - 1); i++) begin
      @(negedge clk_out);
      compare_value({31'b0, clk_led}, {31'b0, i >= 2 ** (LED_LEN - 1)},
                    $sformatf("heartbeat led at cycle %0d", i));
    end
    compare_value({31'b0, rst_led}, 32'd1, "reset led after reset");

    // clock output runs at half the board clock
    @(posedge clk_out);
    t_rise = $time;
    @(posedge clk_out);
    period_ns = $time - t_rise;
    compare_value(period_ns, 2 * CLK_PERIOD, "clock output period");

    for (int i = 0; i < table_q.size(); i++) begin
      row = table_q[i];
      case (row.op)
        OP_WRITE: bus_access(1'b1, row.sel[BUS_AW-1:0], row.data, '0, row.exp_err);
        OP_READ:  bus_access(1'b0, row.sel[BUS_AW-1:0], '0, row.expd, row.exp_err);
        OP_PIN: begin
          @(posedge clk_out);
          pin_oe  <= row.sel[GPIO_W-1:0];
          pin_val <= row.data[GPIO_W-1:0];
        end
        OP_STRAP: begin
          @(posedge clk_out);
          boot_select        <= row.data[0];
          execute_from_flash <= row.data[1];
        end
        OP_WAIT: repeat (row.data) @(posedge clk_out);
        OP_PADS: begin
          @(negedge clk_out);
          compare_value({12'b0, gpio_io}, row.expd, $sformatf("pin levels, row %0d", i));
        end
        OP_OUTS: begin
          @(negedge clk_out);
          compare_value({29'b0, gpio_intr, exit_valid, exit_value}, row.expd,
                        $sformatf("interrupt and exit outputs, row %0d", i));
        end
        default: compare_value({29'b0, row.op}, 32'd0, "unknown table operation");
      endcase
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- sim.f
rtl/mcu_pkg.sv
rtl/board_clock_reset.sv
rtl/soc_ctrl_regs.sv
rtl/gpio_port.sv
rtl/mini_mcu_system.sv
rtl/board_wrapper.sv
tb/tb_board_wrapper.sv
